/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ram_writer
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Result: PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* common/axi_bus_pkg.sv */
`default_nettype none
`include "ram_writer_settings.svh"

package axi_bus_pkg;

  typedef logic [`RW_AXI_ADDR_W-1:0]  axi_addr_t;  // Byte address
  typedef logic [`RW_WORD_ADDR_W-1:0] word_addr_t; // Word index
  typedef logic [`RW_ID_W-1:0]        axi_id_t;
  typedef logic [`RW_DATA_W-1:0]      axi_data_t;

  // Write address channel
  typedef struct packed {
    axi_id_t   id;
    axi_addr_t addr;
    logic [3:0] len;   // Beats minus one
    logic [2:0] size;  // Log2 of bytes per beat
    logic [1:0] burst;
    logic [3:0] cache;
  } aw_chan_t;

  // AXI3 write data channel still carries the ID
  typedef struct packed {
    axi_id_t   id;
    axi_data_t data;
    logic [`RW_DATA_W/8-1:0] strb;
    logic      last;
  } w_chan_t;

endpackage

`default_nettype wire

/* common/capture_ctl_pkg.sv */
`default_nettype none
`include "ram_writer_settings.svh"

package capture_ctl_pkg;

  typedef logic [`RW_AXI_ADDR_W-1:0] host_data_t;

  typedef enum logic {op_set_base, op_read_count} host_op_e;

  typedef struct packed {
    host_op_e   op;
    host_data_t wdata; // New base address
  } host_cmd_t;

  typedef struct packed {
    host_data_t rdata;
  } host_rsp_t;

  typedef enum logic [1:0] {st_idle, st_burst, st_drain} burst_state_e;

  typedef enum logic [1:0] {ps_wait_req, ps_ack, ps_wait_drop} port_state_e;

endpackage

`default_nettype wire

/* common/ram_writer_settings.svh */
`ifndef RAM_WRITER_SETTINGS_SVH
`define RAM_WRITER_SETTINGS_SVH

// Stream word and AXI data beat width
`define RW_DATA_W 64

// Capture buffer size in words
`define RW_FIFO_DEPTH 64

// Beats per AXI3 burst
`define RW_BURST_LEN 16

`define RW_ID_W 6         // Wraps every 64 bursts
`define RW_WORD_ADDR_W 20 // Index of 64-bit words
`define RW_AXI_ADDR_W 32  // Byte address on the bus

`endif

/* project.f */
+incdir+common
common/axi_bus_pkg.sv
common/capture_ctl_pkg.sv
ram_writer/stream_fifo.sv
ram_writer/burst_writer.sv
verilog/cfg_port.sv
verilog/ram_writer_top.sv
tests/ram_writer_assertions.sv
tests/tb_ram_writer.sv

/* ram_writer/burst_writer.sv */
`timescale 1ns/1ns
`default_nettype none
`include "ram_writer_settings.svh"

module burst_writer
(
  input  wire                          aclk,
  input  wire                          aresetn,
  input  wire  axi_bus_pkg::axi_addr_t base_addr,
  input  wire  axi_bus_pkg::axi_data_t fifo_data,
  input  wire                          burst_avail,
  output logic                         fifo_pop,
  output axi_bus_pkg::aw_chan_t        aw,
  output logic                         awvalid,
  input  wire                          awready,
  output axi_bus_pkg::w_chan_t         w,
  output logic                         wvalid,
  input  wire                          wready,
  input  wire                          bvalid,
  output logic                         bready,
  output axi_bus_pkg::word_addr_t      word_count
);
  localparam int BEAT_W     = $clog2(`RW_BURST_LEN);
  localparam int BYTE_SHIFT = $clog2(`RW_DATA_W / 8);

  capture_ctl_pkg::burst_state_e state;
  axi_bus_pkg::word_addr_t       word_addr;
  axi_bus_pkg::word_addr_t       next_word;
  axi_bus_pkg::axi_id_t          wid;
  axi_bus_pkg::axi_id_t          aw_id;
  axi_bus_pkg::axi_addr_t        aw_addr;
  axi_bus_pkg::axi_addr_t        start_addr;
  axi_bus_pkg::axi_addr_t        next_addr;
  logic [`RW_ID_W:0]             pending;
  logic                          aw_hs;
  logic                          w_hs;
  logic                          w_last;

  assign aw_hs      = awvalid & awready;
  assign w_hs       = wvalid & wready;
  assign w_last     = &word_addr[BEAT_W-1:0]; // Word index closes a burst
  assign next_word  = word_addr + 1'b1;
  assign start_addr = base_addr + (axi_bus_pkg::axi_addr_t'(word_addr) << BYTE_SHIFT);
  assign next_addr  = base_addr + (axi_bus_pkg::axi_addr_t'(next_word) << BYTE_SHIFT);

  assign fifo_pop   = w_hs;
  assign bready     = |pending;
  assign word_count = word_addr;

  assign aw = axi_bus_pkg::aw_chan_t'{id: aw_id, addr: aw_addr,
                                      len: 4'(`RW_BURST_LEN - 1), size: 3'(BYTE_SHIFT),
                                      burst: 2'b01, cache: 4'b1111}; // INCR, cacheable
  assign w  = axi_bus_pkg::w_chan_t'{id: wid, data: fifo_data, strb: '1, last: w_last};

  always_ff @(posedge aclk)
  begin
    if (~aresetn)
    begin
      state     <= capture_ctl_pkg::st_idle;
      awvalid   <= 1'b0;
      wvalid    <= 1'b0;
      word_addr <= '0;
      wid       <= '0;
      pending   <= '0;
    end
    else
    begin
      if (w_hs)
      begin
        word_addr <= next_word;
        if (w_last)
        begin
          wid <= wid + 1'b1;
        end
      end
      case ({aw_hs, bvalid & bready})
        2'b10:   pending <= pending + 1'b1;
        2'b01:   pending <= pending - 1'b1;
        default: pending <= pending;
      endcase
      unique case (state)
        capture_ctl_pkg::st_idle:
        begin
          if (burst_avail)
          begin
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
            aw_addr <= start_addr;
            aw_id   <= wid;
            state   <= capture_ctl_pkg::st_burst;
          end
        end
        capture_ctl_pkg::st_burst:
        begin
          if (w_hs && w_last)
          begin
            if (awvalid && !awready)
            begin
              wvalid <= 1'b0; // Data ran ahead of its address
              state  <= capture_ctl_pkg::st_drain;
            end
            else if (burst_avail)
            begin
              awvalid <= 1'b1; // Next burst follows without a gap
              aw_addr <= next_addr;
              aw_id   <= wid + 1'b1;
            end
            else
            begin
              awvalid <= 1'b0;
              wvalid  <= 1'b0;
              state   <= capture_ctl_pkg::st_idle;
            end
          end
          else if (aw_hs)
          begin
            awvalid <= 1'b0;
          end
        end
        capture_ctl_pkg::st_drain:
        begin
          if (awready)
          begin
            awvalid <= 1'b0;
            state   <= capture_ctl_pkg::st_idle;
          end
        end
        default: state <= capture_ctl_pkg::st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* ram_writer/stream_fifo.sv */
`timescale 1ns/1ns
`default_nettype none
`include "ram_writer_settings.svh"

module stream_fifo
(
  input  wire                          aclk,
  input  wire                          aresetn,
  input  wire  axi_bus_pkg::axi_data_t in_data,
  input  wire                          in_valid,
  output logic                         in_ready,
  output axi_bus_pkg::axi_data_t       out_data,
  input  wire                          fifo_pop,
  output logic                         burst_avail
);
  localparam int PTR_W = $clog2(`RW_FIFO_DEPTH);
  localparam logic [PTR_W:0] FULL_COUNT  = `RW_FIFO_DEPTH;
  localparam logic [PTR_W:0] BURST_COUNT = `RW_BURST_LEN;

  axi_bus_pkg::axi_data_t mem [`RW_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic [PTR_W:0]   free_count;
  logic             full;
  logic             push;

  assign full        = (count == FULL_COUNT);
  assign in_ready    = ~full;
  assign push        = in_valid & in_ready;
  assign out_data    = mem[rd_ptr];                          // Head word falls through
  assign free_count  = count - {{PTR_W{1'b0}}, fifo_pop};    // Word leaving now is taken
  assign burst_avail = (free_count >= BURST_COUNT);

  always_ff @(posedge aclk)
  begin
    if (push)
    begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (~aresetn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= wr_ptr + 1'b1; // Wraps with the buffer
      end
      if (fifo_pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, fifo_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* tests/ram_writer_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module ram_writer_assertions
(
  input wire                             aclk,
  input wire                             aresetn,
  input wire                             awvalid,
  input wire                             awready,
  input wire axi_bus_pkg::aw_chan_t      aw,
  input wire                             wvalid,
  input wire                             wready,
  input wire axi_bus_pkg::w_chan_t       w,
  input wire                             host_req,
  input wire                             host_ack
);
  // Address phase held until accepted
  assert property (@(posedge aclk) disable iff (!aresetn)
    awvalid && !awready |=> awvalid && $stable(aw)) else $error("awvalid dropped or aw changed");

  assert property (@(posedge aclk) disable iff (!aresetn)
    wvalid && !wready |=> wvalid && $stable(w)) else $error("wvalid dropped or w changed");

  // Four-phase host handshake, one cycle each way
  assert property (@(posedge aclk) disable iff (!aresetn)
    $rose(host_req) |=> host_ack) else $error("host_ack late");

  assert property (@(posedge aclk) disable iff (!aresetn)
    host_ack && !host_req |=> !host_ack) else $error("host_ack held after req drop");

endmodule

bind ram_writer_top ram_writer_assertions i_ram_writer_assertions (.*);

`default_nettype wire

/* tests/tb_ram_writer.sv */
`timescale 1ns/1ns
`default_nettype none
`include "ram_writer_settings.svh"

module tb_ram_writer;
  localparam int NUM_WORDS = 16 + 64 + 200 + 16;
  localparam int TIMEOUT   = 64 * NUM_WORDS + 2000;
  localparam logic [31:0] NEW_BASE = 32'h0010_0000;

  logic aclk = 1'b0, aresetn, s_tvalid, s_tready, awvalid, awready, wvalid, wready;
  logic bvalid, bready, host_req, host_ack, stall_w, b_hs;
  axi_bus_pkg::axi_data_t s_tdata;
  axi_bus_pkg::aw_chan_t aw;
  axi_bus_pkg::w_chan_t w;
  capture_ctl_pkg::host_cmd_t host_cmd;
  capture_ctl_pkg::host_rsp_t host_rsp;
  logic [63:0] ref_q [$];            // Accepted stream words in order
  logic [31:0] aw_q [$];
  axi_bus_pkg::w_chan_t w_q [$];     // Beats waiting for their address
  logic [63:0] mem [logic [31:0]];
  logic [31:0] burst_addr [int];
  logic [31:0] model_base = '0, rd;
  int errors = 0, checks = 0, cycles = 0, aw_cnt = 0, beats = 0, beat_in = 0;
  int resp_avail = 0, bursts_acked = 0, sent = 0;

  ram_writer_top i_ram_writer_top (.*);

  always #10 aclk = ~aclk;

  task automatic compare(input string msg, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %0t %s: got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic send_words(input int n, input int max_gap);
    @(posedge aclk);
    #2;
    for (int i = 0; i < n; i++)
    begin
      s_tvalid = 1'b1;
      s_tdata  = ($urandom % 2) ? {$urandom, $urandom} : 64'(sent); // Counter or random
      @(negedge aclk);
      while (!s_tready) @(negedge aclk);
      @(posedge aclk);
      #2;
      s_tvalid = 1'b0;
      sent++;
      repeat ($urandom % (max_gap + 1)) @(posedge aclk);
      #2;
    end
  endtask

  task automatic host_op(input capture_ctl_pkg::host_op_e op, input logic [31:0] wdata,
                         output logic [31:0] rdata);
    @(posedge aclk);
    #2;
    host_cmd = '{op: op, wdata: wdata};
    host_req = 1'b1;
    do @(negedge aclk); while (!host_ack);
    rdata = host_rsp.rdata;
    @(posedge aclk);
    #2;
    host_req = 1'b0;
    do @(negedge aclk); while (host_ack);
  endtask

  task automatic wait_settled();
    do @(negedge aclk);
    while (bursts_acked != ref_q.size() / 16 || beats != 16 * (ref_q.size() / 16));
  endtask

  // Random AXI slave that drives its inputs 2 ns after the edge
  always @(posedge aclk)
  begin
    #2;
    awready = ($urandom % 4) != 0;
    wready  = !stall_w && (($urandom % 4) != 0);
    if (!(bvalid && !b_hs))
      bvalid = (resp_avail > 0) && (($urandom % 3) == 0);
    b_hs = 1'b0;
  end

  // Handshake monitor samples at the falling edge where all signals are stable
  always @(negedge aclk)
  begin
    if (aresetn) compare("bready", 64'(bready), 64'(aw_cnt != bursts_acked));
    if (aresetn && s_tvalid && s_tready) ref_q.push_back(s_tdata);
    if (awvalid && awready)
    begin
      compare("aw addr", 64'(aw.addr), 64'(model_base + 32'(128 * aw_cnt)));
      compare("aw id", 64'(aw.id), 64'(aw_cnt % 64));
      compare("aw form", 64'({aw.len, aw.size, aw.burst, aw.cache}),
              64'({4'd15, 3'd3, 2'b01, 4'b1111}));
      burst_addr[aw_cnt] = model_base + 32'(128 * aw_cnt);
      aw_q.push_back(aw.addr);
      aw_cnt++;
    end
    if (wvalid && wready)
    begin
      compare("w id", 64'(w.id), 64'((beats / 16) % 64));
      compare("w last", 64'(w.last), 64'(beats % 16 == 15));
      compare("w strb", 64'(w.strb), 64'hff);
      w_q.push_back(w);
      beats++;
    end
    while (aw_q.size() > 0 && w_q.size() > 0)
    begin
      mem[aw_q[0] + 32'(8 * beat_in)] = w_q.pop_front().data;
      beat_in++;
      if (beat_in == 16)
      begin
        void'(aw_q.pop_front());
        beat_in = 0;
        resp_avail++;
      end
    end
    if (bvalid && bready)
    begin
      b_hs = 1'b1;
      resp_avail--;
      bursts_acked++;
    end
  end

  always @(posedge aclk)
  begin
    cycles++;
    if (cycles >= TIMEOUT)
    begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial
  begin
    void'($urandom(89294));
    {aresetn, s_tvalid, awready, wready, bvalid, host_req, stall_w, b_hs} = '0;
    s_tdata  = '0;
    host_cmd = '0;
    repeat (16) @(posedge aclk);
    #2;
    aresetn = 1'b1;
    send_words(10, 2);                            // Partial burst stays buffered
    repeat (100) @(posedge aclk);
    compare("bursts for a partial tail", 64'(aw_cnt), 64'd0);
    send_words(6, 2);
    wait_settled();
    compare("bursts after 16 words", 64'(aw_cnt), 64'd1);
    stall_w = 1'b1;                               // Fill the FIFO behind a stalled wready
    send_words(63, 0);
    @(negedge aclk);
    compare("s_tready below full", 64'(s_tready), 64'd1);
    send_words(1, 0);
    repeat (4) @(negedge aclk);
    compare("s_tready with full FIFO", 64'(s_tready), 64'd0);
    stall_w = 1'b0;
    send_words(200, 3);
    wait_settled();
    host_op(capture_ctl_pkg::op_read_count, '0, rd);
    compare("word count", 64'(rd), 64'(beats));
    host_op(capture_ctl_pkg::op_set_base, NEW_BASE, rd);
    model_base = NEW_BASE;                        // New base applies to the current count
    send_words(16, 2);
    wait_settled();
    for (int n = 0; n < 16 * bursts_acked; n++)
      compare("memory word", mem[burst_addr[n / 16] + 32'(8 * (n % 16))], ref_q[n]);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/cfg_port.sv */
`timescale 1ns/1ns
`default_nettype none

module cfg_port
(
  input  wire                              aclk,
  input  wire                              aresetn,
  input  wire                              host_req,
  input  wire  capture_ctl_pkg::host_cmd_t host_cmd,
  output logic                             host_ack,
  output capture_ctl_pkg::host_rsp_t       host_rsp,
  input  wire  axi_bus_pkg::word_addr_t    word_count,
  output axi_bus_pkg::axi_addr_t           base_addr
);
  capture_ctl_pkg::port_state_e state;

  assign host_ack = (state != capture_ctl_pkg::ps_wait_req); // Held until req drops

  always_ff @(posedge aclk)
  begin
    if (~aresetn)
    begin
      state     <= capture_ctl_pkg::ps_wait_req;
      base_addr <= '0;
    end
    else
    begin
      unique case (state)
        capture_ctl_pkg::ps_wait_req:
        begin
          if (host_req)
          begin
            if (host_cmd.op == capture_ctl_pkg::op_set_base)
            begin
              base_addr <= axi_bus_pkg::axi_addr_t'(host_cmd.wdata);
            end
            host_rsp.rdata <= capture_ctl_pkg::host_data_t'(word_count); // Zero-extended
            state          <= capture_ctl_pkg::ps_ack;
          end
        end
        capture_ctl_pkg::ps_ack:
          state <= host_req ? capture_ctl_pkg::ps_wait_drop : capture_ctl_pkg::ps_wait_req;
        capture_ctl_pkg::ps_wait_drop:
        begin
          if (!host_req)
          begin
            state <= capture_ctl_pkg::ps_wait_req;
          end
        end
        default: state <= capture_ctl_pkg::ps_wait_req;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/ram_writer_top.sv */
`timescale 1ns/1ns
`default_nettype none

module ram_writer_top
(
  input  wire                              aclk,
  input  wire                              aresetn,
  input  wire  axi_bus_pkg::axi_data_t     s_tdata,
  input  wire                              s_tvalid,
  output logic                             s_tready,
  output axi_bus_pkg::aw_chan_t            aw,
  output logic                             awvalid,
  input  wire                              awready,
  output axi_bus_pkg::w_chan_t             w,
  output logic                             wvalid,
  input  wire                              wready,
  input  wire                              bvalid,
  output logic                             bready,
  input  wire                              host_req,
  input  wire  capture_ctl_pkg::host_cmd_t host_cmd,
  output logic                             host_ack,
  output capture_ctl_pkg::host_rsp_t       host_rsp
);
  axi_bus_pkg::axi_data_t  fifo_data;
  logic                    burst_avail;
  logic                    fifo_pop;
  axi_bus_pkg::axi_addr_t  base_addr;
  axi_bus_pkg::word_addr_t word_count;

  stream_fifo i_stream_fifo (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .in_data     (s_tdata),
    .in_valid    (s_tvalid),
    .in_ready    (s_tready),
    .out_data    (fifo_data),
    .fifo_pop    (fifo_pop),
    .burst_avail (burst_avail)
  );

  burst_writer i_burst_writer (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .base_addr   (base_addr),
    .fifo_data   (fifo_data),
    .burst_avail (burst_avail),
    .fifo_pop    (fifo_pop),
    .aw          (aw),
    .awvalid     (awvalid),
    .awready     (awready),
    .w           (w),
    .wvalid      (wvalid),
    .wready      (wready),
    .bvalid      (bvalid),
    .bready      (bready),
    .word_count  (word_count)
  );

  cfg_port i_cfg_port (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .host_req   (host_req),
    .host_cmd   (host_cmd),
    .host_ack   (host_ack),
    .host_rsp   (host_rsp),
    .word_count (word_count),
    .base_addr  (base_addr)
  );

endmodule

`default_nettype wire
